//--- build.f
+incdir+verilog
verilog/adc_ctrl_pkg.sv
verilog/adc_stream_pkg.sv
verilog/adc_sequencer.sv
verilog/pattern_source.sv
verilog/lane_fifo.sv
verilog/lane_drain.sv
verilog/adc_test_top.sv
verif/adc_test_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' build.f) verilog/adc_test_macros.svh

.PHONY: all run clean

all: obj_dir/Vadc_test_tb

obj_dir/Vadc_test_tb: build.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module adc_test_tb -f build.f -o Vadc_test_tb

run: obj_dir/Vadc_test_tb
	@out="$$(./obj_dir/Vadc_test_tb)"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

//--- verif/adc_test_tb.sv
`timescale 1ns/100ps
`include "adc_test_macros.svh"

module adc_test_tb;
    import adc_ctrl_pkg::*;
    import adc_stream_pkg::*;

    localparam int TOTAL = `ADC_LANES * `ADC_BURST_LEN;
    localparam logic [3:0] M_INIT = 4'b1000;
    localparam logic [3:0] M_TYPE = 4'b0100;
    localparam logic [3:0] M_CONF = 4'b0010;
    localparam logic [3:0] M_CONV = 4'b0001;

    logic       clk;
    logic       rst;
    cmd_req_t   req;
    cmd_word_t  cmd;
    logic       drain_en;
    cmd_done_t  done;
    stat_word_t stat;
    sample_t    sample;
    logic       sample_valid;

    int         errors;
    int         checks;
    int         test_errors;
    string      test_name;
    int         rx_cnt [`ADC_LANES];
    int         rx_total;
    logic [3:0] freq;

    adc_test_top adc_test_top_inst (
        .clk(clk), .rst(rst), .req(req), .cmd(cmd), .drain_en(drain_en),
        .done(done), .stat(stat), .sample(sample), .sample_valid(sample_valid)
    );

    always #2 clk = ~clk;

    // bias byte of the lane plus the byte index, mod 256.
    function automatic logic [7:0] exp_byte(input int lane, input int idx);
        logic [63:0] bias;
        bias = 64'h01030507090B0D0F;
        return 8'(bias[lane*8 +: 8] + idx[7:0]);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // every drained byte against the lane pattern.
    always @(negedge clk) begin
        if (!rst && sample_valid) begin
            if (rx_cnt[sample.lane] >= `ADC_BURST_LEN) begin
                errors++;
                $display("%s: lane %0d sent more bytes than one burst", test_name, sample.lane);
            end else begin
                check($sformatf("%s lane %0d byte %0d", test_name, sample.lane,
                                rx_cnt[sample.lane]),
                      exp_byte(int'(sample.lane), rx_cnt[sample.lane]), sample.data);
            end
            rx_cnt[sample.lane]++;
            rx_total++;
        end
    end

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) $display("%s: pass", test_name);
        else $display("%s: %0d errors", test_name, errors - test_errors);
    endtask

    task automatic clear_rx();
        rx_total = 0;
        for (int l = 0; l < `ADC_LANES; l++) rx_cnt[l] = 0;
    endtask

    task automatic set_req(input logic [3:0] bits);
        @(posedge clk);
        #1;
        req = cmd_req_t'(bits);
    endtask

    task automatic wait_done(input logic [3:0] mask, input logic level, input int limit);
        logic hit;
        hit = 1'b0;
        for (int n = 0; n < limit && !hit; n++) begin
            @(negedge clk);
            hit = (((4'(done) & mask) != 4'b0000) == level);
        end
        if (!hit) begin
            errors++;
            $display("%s: done %b did not go %0d in time", test_name, mask, level);
        end
    endtask

    // raise, wait for done, drop, wait for done to fall.
    task automatic run_command(input logic [3:0] mask, input int limit);
        set_req(mask);
        wait_done(mask, 1'b1, limit);
        set_req(4'b0000);
        check({test_name, " done held"}, 32'd1, 32'((4'(done) & mask) != 4'b0000));
        wait_done(mask, 1'b0, 4);
    endtask

    task automatic check_counts();
        for (int l = 0; l < `ADC_LANES; l++) begin
            check($sformatf("%s lane %0d count", test_name, l), `ADC_BURST_LEN, rx_cnt[l]);
        end
    endtask

    initial begin
        int   seed;
        logic stalled_early;
        logic hit;
        seed = $urandom(59287);
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        cmd = '0;
        drain_en = 1'b0;
        errors = 0;
        checks = 0;
        test_name = "reset";
        clear_rx();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        begin_test("reset");
        @(negedge clk);
        check("reset done", 32'd0, 32'(4'(done)));
        check("reset stat", 32'd0, stat);
        check("reset sample_valid", 32'd0, 32'(sample_valid));
        end_test();

        begin_test("type");
        run_command(M_TYPE, 100);
        check("type dev_type", 32'hFF, 32'(stat.dev_type));
        check("type flag", 32'd1, 32'(stat.flags[2]));
        end_test();

        begin_test("conf");
        @(posedge clk);
        #1;
        cmd  = cmd_word_t'($urandom);
        freq = cmd.freq_samp;
        run_command(M_CONF, 100);
        check("conf temp", 32'h73F4, 32'(stat.temp));
        check("conf freq_samp", 32'(freq), 32'(stat.freq_samp));
        check("conf flag", 32'd1, 32'(stat.flags[1]));
        end_test();

        begin_test("init");
        run_command(M_INIT, 100);
        check("init flag", 32'd1, 32'(stat.flags[3]));
        set_req(M_INIT | M_CONV);  // init wins over conv.
        wait_done(M_INIT, 1'b1, 100);
        check("init priority done", 32'(M_INIT), 32'(4'(done)));
        check("init priority conv flag", 32'd0, 32'(stat.flags[0]));
        set_req(4'b0000);
        wait_done(M_INIT, 1'b0, 4);
        end_test();

        begin_test("convert");
        clear_rx();
        @(posedge clk);
        #1;
        drain_en = 1'b1;
        set_req(M_CONV);
        wait_done(M_CONV, 1'b1, 2000);
        hit = 1'b0;
        for (int n = 0; n < 500 && !hit; n++) begin
            @(posedge clk);
            hit = (rx_total >= TOTAL);
        end
        if (!hit) begin
            errors++;
            $display("convert: only %0d of %0d bytes arrived in time", rx_total, TOTAL);
        end
        set_req(4'b0000);
        wait_done(M_CONV, 1'b0, 4);
        check_counts();
        check("convert flag", 32'd1, 32'(stat.flags[0]));
        end_test();

        begin_test("stall");
        clear_rx();
        @(posedge clk);
        #1;
        drain_en = 1'b0;
        set_req(M_CONV);
        stalled_early = 1'b0;
        for (int n = 0; n < 200; n++) begin
            @(negedge clk);
            if (done.conv) stalled_early = 1'b1;
        end
        check("stall done.conv", 32'd0, 32'(stalled_early));
        check("stall samples", 32'd0, rx_total);
        hit = 1'b0;
        for (int n = 0; n < 4000 && !hit; n++) begin
            @(posedge clk);
            #1;
            drain_en = (($urandom % 2) == 1);
            hit = (rx_total >= TOTAL);
        end
        if (!hit) begin
            errors++;
            $display("stall: only %0d of %0d bytes arrived in time", rx_total, TOTAL);
        end
        wait_done(M_CONV, 1'b1, 100);
        @(posedge clk);
        #1;
        drain_en = 1'b0;
        set_req(4'b0000);
        wait_done(M_CONV, 1'b0, 4);
        check_counts();
        end_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/adc_test_top.sv
`timescale 1ns/100ps
`include "adc_test_macros.svh"

module adc_test_top (
    input  logic                     clk,
    input  logic                     rst,
    input  adc_ctrl_pkg::cmd_req_t   req,
    input  adc_ctrl_pkg::cmd_word_t  cmd,
    input  logic                     drain_en,
    output adc_ctrl_pkg::cmd_done_t  done,
    output adc_ctrl_pkg::stat_word_t stat,
    output adc_stream_pkg::sample_t  sample,
    output logic                     sample_valid
);
    import adc_stream_pkg::*;

    logic        conv_busy;
    logic        burst_done;
    lane_bits_t  wr_en;
    lane_bits_t  rd_en;
    lane_bits_t  full;
    lane_bits_t  empty;
    lane_bytes_t wr_data;
    lane_bytes_t rd_data;

    adc_sequencer adc_sequencer_inst (
        .clk(clk), .rst(rst), .req(req), .cmd(cmd), .burst_done(burst_done),
        .done(done), .conv_busy(conv_busy), .stat(stat)
    );

    pattern_source pattern_source_inst (
        .clk(clk), .rst(rst), .conv_busy(conv_busy), .full(full),
        .wr_en(wr_en), .wr_data(wr_data), .burst_done(burst_done)
    );

    for (genvar i = 0; i < `ADC_LANES; i++) begin : lane_gen
        lane_fifo lane_fifo_inst (
            .clk(clk), .rst(rst), .wr_en(wr_en[i]), .wr_data(wr_data[i]),
            .rd_en(rd_en[i]), .rd_data(rd_data[i]), .full(full[i]), .empty(empty[i])
        );
    end

    lane_drain lane_drain_inst (
        .clk(clk), .rst(rst), .drain_en(drain_en), .empty(empty), .rd_data(rd_data),
        .rd_en(rd_en), .sample(sample), .sample_valid(sample_valid)
    );

endmodule

//--- verilog/lane_drain.sv
`timescale 1ns/100ps
`include "adc_test_macros.svh"

module lane_drain (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        drain_en,
    input  adc_stream_pkg::lane_bits_t  empty,
    input  adc_stream_pkg::lane_bytes_t rd_data,
    output adc_stream_pkg::lane_bits_t  rd_en,
    output adc_stream_pkg::sample_t     sample,
    output logic                        sample_valid
);
    import adc_stream_pkg::*;

    localparam int LW = $clog2(`ADC_LANES);

    logic [LW-1:0] last_q;
    logic [LW-1:0] cand;
    logic [LW-1:0] pick;
    logic          found;
    lane_bits_t    rd_sel;

    // first non-empty lane after the one last served.
    always_comb begin
        found = 1'b0;
        pick  = last_q;
        cand  = last_q;
        for (int i = 1; i <= `ADC_LANES; i++) begin
            cand = last_q + LW'(i);
            if (!found && !empty[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
        rd_sel = '0;
        if (drain_en && found) rd_sel[pick] = 1'b1;  // one pop per cycle.
    end

    assign rd_en = rd_sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q       <= LW'(`ADC_LANES - 1);  // lane 0 goes first.
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= |rd_sel;
            if (|rd_sel) last_q <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (|rd_sel) sample <= '{lane: pick, data: rd_data[pick]};
    end

endmodule

//--- verilog/lane_fifo.sv
`timescale 1ns/100ps
`include "adc_test_macros.svh"

module lane_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       full,
    output logic       empty
);

    localparam int DEPTH = `ADC_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]  mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);

    assign do_wr = wr_en && !full;  // dropped when full.
    assign do_rd = rd_en && !empty;

    // show-ahead, head entry always on the output.
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

endmodule

//--- verilog/pattern_source.sv
`timescale 1ns/100ps
`include "adc_test_macros.svh"

module pattern_source (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        conv_busy,
    input  adc_stream_pkg::lane_bits_t  full,
    output adc_stream_pkg::lane_bits_t  wr_en,
    output adc_stream_pkg::lane_bytes_t wr_data,
    output logic                        burst_done
);
    import adc_stream_pkg::*;

    localparam lane_bytes_t BIAS = `ADC_BIAS;

    logic [7:0] cnt [`ADC_LANES];
    lane_bits_t lane_done;

    always_comb begin
        for (int i = 0; i < `ADC_LANES; i++) begin
            lane_done[i] = (cnt[i] >= 8'(`ADC_BURST_LEN));
            wr_en[i]     = conv_busy && !full[i] && !lane_done[i];
            wr_data[i]   = BIAS[i] + cnt[i];  // wraps at 256.
        end
    end

    // level for the sequencer, dropped with conv_busy.
    assign burst_done = conv_busy && (&lane_done);

    // lanes advance on their own.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ADC_LANES; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `ADC_LANES; i++) begin
                if (!conv_busy) begin
                    cnt[i] <= '0;
                end else if (wr_en[i]) begin
                    cnt[i] <= cnt[i] + 8'd1;
                end
            end
        end
    end

endmodule

//--- verilog/adc_sequencer.sv
`timescale 1ns/100ps
`include "adc_test_macros.svh"

module adc_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  adc_ctrl_pkg::cmd_req_t   req,
    input  adc_ctrl_pkg::cmd_word_t  cmd,
    input  logic                     burst_done,
    output adc_ctrl_pkg::cmd_done_t  done,
    output logic                     conv_busy,
    output adc_ctrl_pkg::stat_word_t stat
);
    import adc_ctrl_pkg::*;

    seq_state_t  state_q;
    seq_state_t  state_d;
    logic [11:0] num;
    logic [7:0]  dev_type_q;
    logic [15:0] temp_q;
    logic [3:0]  freq_q;
    logic [3:0]  flags_q;

    assign done.init = (state_q == INIT_DONE);
    assign done.typ  = (state_q == TYPE_DONE);
    assign done.conf = (state_q == CONF_DONE);
    assign done.conv = (state_q == CONV_DONE);
    assign conv_busy = (state_q == CONV_WORK);  // runs the producer.

    assign stat = {temp_q, dev_type_q, flags_q, freq_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: state_d = WAIT;
            WAIT: begin
                if (req.init) state_d = INIT_IDLE;  // fixed priority.
                else if (req.typ) state_d = TYPE_IDLE;
                else if (req.conf) state_d = CONF_IDLE;
                else if (req.conv) state_d = CONV_IDLE;
            end
            INIT_IDLE: state_d = INIT_WORK;
            INIT_WORK: begin
                if (num >= `ADC_NUM_INIT - 12'd1) state_d = INIT_DONE;
            end
            INIT_DONE: begin
                if (!req.init) state_d = WAIT;
            end
            TYPE_IDLE: state_d = TYPE_WORK;
            TYPE_WORK: begin
                if (num >= `ADC_NUM_TYPE - 12'd1) state_d = TYPE_DONE;
            end
            TYPE_DONE: begin
                if (!req.typ) state_d = WAIT;
            end
            CONF_IDLE: state_d = CONF_WORK;
            CONF_WORK: begin
                if (num >= `ADC_NUM_CONF - 12'd1) state_d = CONF_DONE;
            end
            CONF_DONE: begin
                if (!req.conf) state_d = WAIT;
            end
            CONV_IDLE: state_d = CONV_WORK;
            CONV_WORK: begin
                if (burst_done) state_d = CONV_DONE;  // may stall on full lanes.
            end
            CONV_DONE: begin
                if (!req.conv) state_d = WAIT;
            end
            default: state_d = IDLE;
        endcase
    end

    // counts only inside the timed work states.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= '0;
        end else if (state_q inside {INIT_WORK, TYPE_WORK, CONF_WORK}) begin
            num <= num + 12'd1;
        end else begin
            num <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_type_q <= '0;
            temp_q     <= '0;
            freq_q     <= '0;
            flags_q    <= '0;
        end else begin
            case (state_q)
                TYPE_IDLE: dev_type_q <= `ADC_TYPE_ID;
                CONF_IDLE: begin
                    temp_q <= `ADC_TEMP_VAL;
                    freq_q <= cmd.freq_samp;  // held by host during conf.
                end
                INIT_DONE: flags_q[3] <= 1'b1;
                TYPE_DONE: flags_q[2] <= 1'b1;
                CONF_DONE: flags_q[1] <= 1'b1;
                CONV_DONE: flags_q[0] <= 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/adc_stream_pkg.sv
`include "adc_test_macros.svh"

package adc_stream_pkg;

    // one byte per lane, lane 0 in the low byte.
    typedef logic [`ADC_LANES-1:0][7:0] lane_bytes_t;

    // one bit per lane.
    typedef logic [`ADC_LANES-1:0] lane_bits_t;

    typedef struct packed {
        logic [$clog2(`ADC_LANES)-1:0] lane;
        logic [7:0]                    data;
    } sample_t;

endpackage

//--- verilog/adc_ctrl_pkg.sv
package adc_ctrl_pkg;

    typedef struct packed {
        logic init;
        logic typ;  // type query.
        logic conf;
        logic conv;
    } cmd_req_t;

    typedef struct packed {
        logic init;
        logic typ;
        logic conf;
        logic conv;
    } cmd_done_t;

    typedef struct packed {
        logic [7:0]  spare_hi;
        logic [3:0]  freq_samp;
        logic [3:0]  filt_up;
        logic [3:0]  filt_low;
        logic [11:0] spare_lo;
    } cmd_word_t;

    typedef struct packed {
        logic [15:0] temp;
        logic [7:0]  dev_type;
        logic [3:0]  flags;  // init, type, conf, conv from msb.
        logic [3:0]  freq_samp;
    } stat_word_t;

    typedef enum logic [7:0] {
        IDLE      = 8'h00,
        WAIT      = 8'h01,
        INIT_IDLE = 8'h10, INIT_WORK = 8'h11, INIT_DONE = 8'h12,
        TYPE_IDLE = 8'h20, TYPE_WORK = 8'h21, TYPE_DONE = 8'h22,
        CONF_IDLE = 8'h30, CONF_WORK = 8'h31, CONF_DONE = 8'h32,
        CONV_IDLE = 8'h40, CONV_WORK = 8'h41, CONV_DONE = 8'h42
    } seq_state_t;

endpackage

//--- verilog/adc_test_macros.svh
`ifndef ADC_TEST_MACROS_SVH
`define ADC_TEST_MACROS_SVH

// work state lengths in clk cycles.
`define ADC_NUM_INIT 12'h010
`define ADC_NUM_TYPE 12'h010
`define ADC_NUM_CONF 12'h020

// lane buffers and their depth.
`define ADC_LANES 8
`define ADC_FIFO_DEPTH 16

// bytes written per lane on each convert.
// larger than the depth on purpose.
`define ADC_BURST_LEN 24

// per-lane offset, lane 0 in the low byte.
`define ADC_BIAS 64'h01030507090B0D0F

// fixed identity values.
`define ADC_TYPE_ID 8'hFF
`define ADC_TEMP_VAL 16'h73F4

`endif
